//--- Bender.yml
package:
  name: nabp_swap

sources:
  - verilog/nabp_pkg.sv
  - verilog/nabp_apb_frontend.sv
  - verilog/nabp_swappable.sv
  - verilog/nabp_swap_control.sv
  - verilog/nabp_pe_output.sv
  - verilog/nabp_swap_top.sv
  - target: test
    files:
      - testbench/nabp_swap_props.sv
      - testbench/nabp_swap_tb.sv

//--- nabp_swap.f
verilog/nabp_pkg.sv
verilog/nabp_apb_frontend.sv
verilog/nabp_swappable.sv
verilog/nabp_swap_control.sv
verilog/nabp_pe_output.sv
verilog/nabp_swap_top.sv
testbench/nabp_swap_props.sv
testbench/nabp_swap_tb.sv

//--- testbench/nabp_swap_props.sv
`default_nettype none

module nabp_swap_props
    import nabp_pkg::*;
(
    input wire              clk,
    input wire              reset_n,
    input wire swap_state_t state,
    input wire              fill_ready,
    input wire [1:0]        fill_kick,
    input wire [1:0]        shift_busy,
    input wire pe_beat_t    pe_beat,
    input wire              pe_valid,
    input wire              pe_ready
);

    // held beat stays put until accepted
    hold_stable: assert property (@(posedge clk) disable iff (reset_n)
        pe_valid && !pe_ready |=> pe_valid && $stable(pe_beat))
        else $error("pe_beat or pe_valid changed while held");

    // the swap cycle takes no sample and finds both buffers idle
    swap_blocks_fill: assert property (@(posedge clk) disable iff (reset_n)
        state == ST_SWAP |-> !fill_ready && shift_busy == 2'b00)
        else $error("fill_ready high or a buffer still shifting during the swap cycle");

    // one buffer never fills and shifts at once
    buffers_apart: assert property (@(posedge clk) disable iff (reset_n)
        (fill_kick & shift_busy) == 2'b00)
        else $error("filling buffer is also the shifting buffer");

endmodule

bind nabp_swap_top nabp_swap_props swap_props_i
(
    .clk(clk),
    .reset_n(reset_n),
    .state(swap_control_i.state),
    .fill_ready(fill_ready),
    .fill_kick(swap_control_i.sw_fill_kick),
    .shift_busy(swap_control_i.sw_shift_busy),
    .pe_beat(pe_beat),
    .pe_valid(pe_valid),
    .pe_ready(pe_ready)
);

`default_nettype wire

//--- testbench/nabp_swap_tb.sv
`default_nettype none

module nabp_swap_tb
    import nabp_pkg::*;
();

    typedef logic [kLineLength*kFilteredDataLength-1:0] line_t;

    localparam int kDrive = 10;
    localparam int kRandomLines = 20;
    localparam int kPressureLines = 3;
    localparam int kTotalLines = 1 + 8 + kRandomLines + kPressureLines + 1;
    localparam int kTimeoutCycles = 40 * kTotalLines + 2000;
    localparam int kPatternLength = 256;

    logic          clk;
    logic          reset_n;
    logic          psel;
    logic          penable;
    logic          pwrite;
    logic [3:0]    paddr;
    logic [31:0]   pwdata;
    wire  [31:0]   prdata;
    wire           pready;
    wire           pslverr;
    wire pe_beat_t pe_beat;
    wire           pe_valid;
    logic          pe_ready;

    angle_t      line_angle_q[$];
    line_t       line_data_q[$];
    angle_t      last_angle;
    int          beat_idx;
    int          lines_written;
    int          lines_seen;
    int          beat_errors;
    int          status_errors;
    int          slverr_errors;
    int          other_errors;
    int          stall_cycles;
    int          ready_mode;
    int          pattern_idx;
    int          cycle_count;
    logic        ready_pattern [kPatternLength];
    logic        held;
    pe_beat_t    held_beat;
    int          scan_angles [8] = '{0, 44, 45, 89, 90, 134, 135, 179};

    nabp_swap_top nabp_swap_top_i
    (
        .clk(clk),
        .reset_n(reset_n),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .pe_beat(pe_beat),
        .pe_valid(pe_valid),
        .pe_ready(pe_ready)
    );

    always #50 clk = ~clk;

    // expected window from the line contents and the angle thresholds
    function automatic pe_beat_t ref_beat(input angle_t angle, input line_t line, input int idx);
        pe_beat_t b;
        int       pos;
        b.angle = angle;
        b.index = index_t'(idx);
        b.taps = '0;
        for (int t = 0; t < kNoOfTaps; t++)
        begin
            pos = idx + t;
            if (pos < kLineLength)
                b.taps[t*kFilteredDataLength +: kFilteredDataLength] =
                    line[pos*kFilteredDataLength +: kFilteredDataLength];
        end
        b.scan_mode = (angle < kAngle45 || angle >= kAngle135) ? SCAN_X : SCAN_Y;
        b.scan_dir = (angle < kAngle90) ? DIR_FORWARD : DIR_REVERSE;
        return b;
    endfunction

    task automatic check_beat(input pe_beat_t exp, input pe_beat_t act);
        if (act !== exp)
        begin
            beat_errors++;
            $display("FAIL t=%0t pe_beat expected %h actual %h", $time, exp, act);
        end
    endtask

    task automatic check_status(input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            status_errors++;
            $display("FAIL t=%0t prdata expected %h actual %h", $time, exp, act);
        end
    endtask

    task automatic check_slverr(input logic exp, input logic act);
        if (act !== exp)
        begin
            slverr_errors++;
            $display("FAIL t=%0t pslverr expected %b actual %b", $time, exp, act);
        end
    endtask

    // one APB transfer entered just after a rising edge
    task automatic apb_access(input logic write, input logic [3:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic slverr);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #kDrive;
        penable = 1'b1;
        @(negedge clk);
        while (!pready)
        begin
            stall_cycles++;
            @(negedge clk);
        end
        rdata = prdata;
        slverr = pslverr;
        @(posedge clk);
        #kDrive;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_angle(input int angle, input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, kRegAngle, 32'(angle), rd, err);
        check_slverr(exp_err, err);
        if (!exp_err)
            last_angle = angle_t'(angle);
    endtask

    // random samples under the last accepted angle
    task automatic write_samples();
        line_t       line;
        logic [15:0] s;
        logic [31:0] rd;
        logic        err;
        for (int i = 0; i < kLineLength; i++)
        begin
            s = 16'($urandom);
            line[i*kFilteredDataLength +: kFilteredDataLength] = s;
            apb_access(1'b1, kRegSample, {16'h0, s}, rd, err);
        end
        line_angle_q.push_back(last_angle);
        line_data_q.push_back(line);
        lines_written++;
    endtask

    task automatic write_line(input int angle);
        write_angle(angle, 1'b0);
        write_samples();
    endtask

    task automatic read_status(input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b0, kRegStatus, 32'h0, rd, err);
        check_status(exp, rd);
    endtask

    task automatic wait_drain();
        wait (lines_seen == lines_written);
        @(posedge clk);
        #kDrive;
    endtask

    task automatic take_beat();
        if (line_data_q.size() == 0)
        begin
            other_errors++;
            $display("unexpected beat at t=%0t with no line pending", $time);
        end
        else
        begin
            check_beat(ref_beat(line_angle_q[0], line_data_q[0], beat_idx), pe_beat);
            beat_idx++;
            if (beat_idx == kLineLength)
            begin
                beat_idx = 0;
                void'(line_angle_q.pop_front());
                void'(line_data_q.pop_front());
                lines_seen++;
            end
        end
    endtask

    // pe_ready is high in mode 0, random in mode 1 and low in mode 2
    always @(posedge clk)
    begin
        #kDrive;
        pattern_idx = (pattern_idx + 1) % kPatternLength;
        case (ready_mode)
            0: pe_ready = 1'b1;
            1: pe_ready = ready_pattern[pattern_idx];
            default: pe_ready = 1'b0;
        endcase
    end

    // compare process samples mid cycle where outputs are settled
    always @(negedge clk)
    begin
        if (reset_n)
            held = 1'b0;
        else
        begin
            if (held)
            begin
                if (!pe_valid)
                begin
                    other_errors++;
                    $display("pe_valid dropped at t=%0t while a beat was held", $time);
                end
                check_beat(held_beat, pe_beat);
            end
            held = pe_valid && !pe_ready;
            held_beat = pe_beat;
            if (pe_valid && pe_ready)
                take_beat();
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < kTimeoutCycles)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, %0d of %0d lines seen", cycle_count, lines_seen,
                 lines_written);
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        int total;
        pattern_idx = $urandom(1292) % kPatternLength;
        for (int i = 0; i < kPatternLength; i++)
            ready_pattern[i] = ($urandom % 3) != 0;
        clk = 1'b0;
        reset_n = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        pe_ready = 1'b1;
        ready_mode = 0;
        last_angle = '0;
        beat_idx = 0;
        lines_written = 0;
        lines_seen = 0;
        beat_errors = 0;
        status_errors = 0;
        slverr_errors = 0;
        other_errors = 0;
        stall_cycles = 0;
        repeat (16) @(posedge clk);
        #kDrive;
        reset_n = 1'b0;

        // status after reset and while one line shifts out
        read_status(32'h1);
        write_line($urandom % kAngle180);
        read_status(32'h3);
        wait_drain();
        read_status(32'h1);

        // scan fields around every threshold
        foreach (scan_angles[i])
            write_line(scan_angles[i]);
        wait_drain();

        ready_mode = 1;
        for (int n = 0; n < kRandomLines; n++)
            write_line($urandom % kAngle180);
        wait_drain();

        // long stall on the pe side while lines keep coming
        stall_cycles = 0;
        ready_mode = 2;
        fork
            for (int n = 0; n < kPressureLines; n++)
                write_line($urandom % kAngle180);
            begin
                repeat (300) @(posedge clk);
                ready_mode = 1;
            end
        join
        if (stall_cycles == 0)
        begin
            other_errors++;
            $display("sample writes never waited while pe_ready was held low");
        end
        wait_drain();

        // out of range angles leave the previous one in place
        write_angle(kAngle180, 1'b1);
        write_angle(300, 1'b1);
        write_samples();
        wait_drain();

        repeat (20) @(posedge clk);
        if (line_data_q.size() != 0 || beat_idx != 0)
        begin
            other_errors++;
            $display("lines left over at the end of the run");
        end
        total = beat_errors + status_errors + slverr_errors + other_errors;
        $display("errors: beat %0d status %0d slverr %0d other %0d", beat_errors,
                 status_errors, slverr_errors, other_errors);
        if (total == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/nabp_apb_frontend.sv
`default_nettype none

module nabp_apb_frontend
    import nabp_pkg::*;
(
    input  wire         clk,
    input  wire         reset_n,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [3:0]  paddr,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  wire         fill_ready,
    input  wire         shift_busy,
    output fill_t       fill
);

    angle_t cur_angle;
    index_t cur_index;
    logic   access;
    logic   angle_wr;
    logic   angle_bad;
    logic   sample_wr;

    // access phase decode
    assign access = psel && penable;
    assign angle_wr = access && pwrite && (paddr == kRegAngle);
    assign sample_wr = access && pwrite && (paddr == kRegSample);
    assign angle_bad = (pwdata >= 32'(kAngle180));

    // sample writes wait for the swap controller
    assign pready = sample_wr ? fill_ready : access;
    assign pslverr = angle_wr && angle_bad;

    always_comb
    begin
        prdata = '0;
        case (paddr)
            kRegAngle:
                prdata[kAngleLength-1:0] = cur_angle;
            kRegStatus:
            begin
                prdata[0] = fill_ready;
                prdata[1] = shift_busy;
            end
            default:
                prdata = '0;
        endcase
    end

    // one fill beat per completed sample write
    always_comb
    begin
        fill.valid = sample_wr && fill_ready;
        fill.angle = cur_angle;
        fill.index = cur_index;
        fill.sample = sample_t'(pwdata[kFilteredDataLength-1:0]);
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            cur_angle <= '0;
            cur_index <= '0;
        end
        else if (angle_wr && !angle_bad)
        begin
            // new line starts at sample 0
            cur_angle <= angle_t'(pwdata);
            cur_index <= '0;
        end
        else if (fill.valid)
            cur_index <= cur_index + 1'b1;
    end

endmodule

`default_nettype wire

//--- verilog/nabp_pe_output.sv
`default_nettype none

module nabp_pe_output
    import nabp_pkg::*;
(
    input  wire           clk,
    input  wire           reset_n,
    input  wire pe_beat_t beat,
    input  wire           beat_valid,
    output logic          beat_ready,
    output pe_beat_t      pe_beat,
    output logic          pe_valid,
    input  wire           pe_ready
);

    logic load;

    // free when empty or draining this cycle
    assign beat_ready = !pe_valid || pe_ready;
    assign load = beat_valid && beat_ready;

    always_ff @(posedge clk)
    begin
        if (reset_n)
            pe_valid <= 1'b0;
        else if (beat_ready)
            pe_valid <= beat_valid;
    end

    // payload only moves on a transfer
    always_ff @(posedge clk)
    begin
        if (load)
            pe_beat <= beat;
    end

endmodule

`default_nettype wire

//--- verilog/nabp_pkg.sv
`default_nettype none

package nabp_pkg;

    // angles in whole degrees from 0 to 179
    localparam int kAngleLength = 9;
    localparam int kAngle45 = 45;
    localparam int kAngle90 = 90;
    localparam int kAngle135 = 135;
    localparam int kAngle180 = 180;

    localparam int kFilteredDataLength = 16;
    localparam int kLineLength = 16;
    localparam int kNoOfTaps = 4;
    localparam int kIndexLength = 4;

    // apb register map
    localparam logic [3:0] kRegAngle = 4'h0;
    localparam logic [3:0] kRegSample = 4'h4;
    localparam logic [3:0] kRegStatus = 4'h8;

    typedef logic [kAngleLength-1:0] angle_t;
    typedef logic signed [kFilteredDataLength-1:0] sample_t;
    typedef logic [kIndexLength-1:0] index_t;
    // tap 0 in the lowest bits
    typedef logic [kNoOfTaps*kFilteredDataLength-1:0] taps_t;

    typedef enum logic {SCAN_X, SCAN_Y} scan_mode_t;
    typedef enum logic {DIR_FORWARD, DIR_REVERSE} scan_dir_t;
    typedef enum logic [1:0] {ST_FILL, ST_FILL_SHIFT, ST_WAIT_SHIFT, ST_SWAP} swap_state_t;

    // one sample write heading for the fill buffer
    typedef struct packed {
        logic    valid;
        angle_t  angle;
        index_t  index;
        sample_t sample;
    } fill_t;

    // one tap window for the processing elements
    typedef struct packed {
        angle_t     angle;
        scan_mode_t scan_mode;
        scan_dir_t  scan_dir;
        index_t     index;
        taps_t      taps;
    } pe_beat_t;

endpackage

`default_nettype wire

//--- verilog/nabp_swap_control.sv
`default_nettype none

module nabp_swap_control
    import nabp_pkg::*;
(
    input  wire        clk,
    input  wire        reset_n,
    input  wire fill_t fill,
    output logic       fill_ready,
    output logic       shift_busy,
    output pe_beat_t   beat,
    output logic       beat_valid,
    input  wire        beat_ready
);

    swap_state_t state;
    swap_state_t next_state;
    // sel names the filling buffer and the other one shifts
    logic        sel;
    logic [1:0]  sw_fill_kick;
    logic [1:0]  sw_shift_kick;
    logic [1:0]  sw_shift_advance;
    wire  [1:0]  sw_fill_done;
    wire  [1:0]  sw_shift_busy;
    wire  [1:0]  sw_shift_done;
    wire angle_t sw_angle [2];
    wire index_t sw_index [2];
    wire taps_t  sw_taps [2];
    logic        fill_done;
    logic        shift_done;
    logic        shift_free;
    angle_t      shift_angle;

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            state <= ST_FILL;
            sel <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (state == ST_SWAP)
                sel <= ~sel;
        end
    end

    assign fill_ready = (state == ST_FILL) || (state == ST_FILL_SHIFT);
    assign fill_done = sw_fill_done[sel];
    assign shift_done = sw_shift_done[~sel];
    assign shift_busy = sw_shift_busy[~sel];
    // other buffer idle now or after this edge
    assign shift_free = shift_done || !shift_busy;

    always_comb
    begin
        next_state = state;
        case (state)
            ST_FILL, ST_FILL_SHIFT:
                if (fill_done)
                    next_state = shift_free ? ST_SWAP : ST_WAIT_SHIFT;
                else if (state == ST_FILL_SHIFT && shift_free)
                    next_state = ST_FILL;
            ST_WAIT_SHIFT:
                if (shift_free)
                    next_state = ST_SWAP;
            ST_SWAP:
                next_state = ST_FILL_SHIFT;
            default:
                next_state = ST_FILL;
        endcase
    end

    // kicks go to the buffer that sel points at and beats come from the other
    always_comb
    begin
        sw_fill_kick = '0;
        sw_shift_kick = '0;
        sw_shift_advance = '0;
        sw_fill_kick[sel] = fill_ready;
        sw_shift_kick[sel] = (state == ST_SWAP);
        sw_shift_advance[~sel] = beat_ready;
    end

    nabp_swappable sw0
    (
        .clk(clk),
        .reset_n(reset_n),
        .fill(fill),
        .fill_kick(sw_fill_kick[0]),
        .shift_kick(sw_shift_kick[0]),
        .shift_advance(sw_shift_advance[0]),
        .fill_done(sw_fill_done[0]),
        .shift_busy(sw_shift_busy[0]),
        .shift_done(sw_shift_done[0]),
        .angle(sw_angle[0]),
        .index(sw_index[0]),
        .taps(sw_taps[0])
    );

    nabp_swappable sw1
    (
        .clk(clk),
        .reset_n(reset_n),
        .fill(fill),
        .fill_kick(sw_fill_kick[1]),
        .shift_kick(sw_shift_kick[1]),
        .shift_advance(sw_shift_advance[1]),
        .fill_done(sw_fill_done[1]),
        .shift_busy(sw_shift_busy[1]),
        .shift_done(sw_shift_done[1]),
        .angle(sw_angle[1]),
        .index(sw_index[1]),
        .taps(sw_taps[1])
    );

    assign shift_angle = sw_angle[~sel];
    assign beat_valid = shift_busy;

    always_comb
    begin
        beat.angle = shift_angle;
        beat.index = sw_index[~sel];
        beat.taps = sw_taps[~sel];
        // scan fields from the angle thresholds
        if (shift_angle < kAngle45 || shift_angle >= kAngle135)
            beat.scan_mode = SCAN_X;
        else
            beat.scan_mode = SCAN_Y;
        if (shift_angle < kAngle90)
            beat.scan_dir = DIR_FORWARD;
        else
            beat.scan_dir = DIR_REVERSE;
    end

endmodule

`default_nettype wire

//--- verilog/nabp_swap_top.sv
`default_nettype none

module nabp_swap_top
    import nabp_pkg::*;
(
    input  wire         clk,
    input  wire         reset_n,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [3:0]  paddr,
    input  wire  [31:0] pwdata,
    output wire  [31:0] prdata,
    output wire         pready,
    output wire         pslverr,
    output pe_beat_t    pe_beat,
    output logic        pe_valid,
    input  wire         pe_ready
);

    wire fill_t    fill;
    wire           fill_ready;
    wire           shift_busy;
    wire pe_beat_t beat;
    wire           beat_valid;
    wire           beat_ready;

    nabp_apb_frontend frontend_i
    (
        .clk(clk),
        .reset_n(reset_n),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .fill_ready(fill_ready),
        .shift_busy(shift_busy),
        .fill(fill)
    );

    nabp_swap_control swap_control_i
    (
        .clk(clk),
        .reset_n(reset_n),
        .fill(fill),
        .fill_ready(fill_ready),
        .shift_busy(shift_busy),
        .beat(beat),
        .beat_valid(beat_valid),
        .beat_ready(beat_ready)
    );

    nabp_pe_output pe_output_i
    (
        .clk(clk),
        .reset_n(reset_n),
        .beat(beat),
        .beat_valid(beat_valid),
        .beat_ready(beat_ready),
        .pe_beat(pe_beat),
        .pe_valid(pe_valid),
        .pe_ready(pe_ready)
    );

endmodule

`default_nettype wire

//--- verilog/nabp_swappable.sv
`default_nettype none

module nabp_swappable
    import nabp_pkg::*;
(
    input  wire        clk,
    input  wire        reset_n,
    input  wire fill_t fill,
    input  wire        fill_kick,
    input  wire        shift_kick,
    input  wire        shift_advance,
    output logic       fill_done,
    output logic       shift_busy,
    output logic       shift_done,
    output angle_t     angle,
    output index_t     index,
    output taps_t      taps
);

    sample_t              line_mem [kLineLength];
    angle_t               line_angle;
    index_t               shift_idx;
    logic                 fill_we;
    logic                 last_window;
    logic [kIndexLength:0] pos;

    assign fill_we = fill_kick && fill.valid;
    assign fill_done = fill_we && (fill.index == index_t'(kLineLength-1));

    // line storage
    always_ff @(posedge clk)
    begin
        if (fill_we)
        begin
            line_mem[fill.index] <= fill.sample;
            line_angle <= fill.angle;
        end
    end

    assign last_window = (shift_idx == index_t'(kLineLength-1));
    assign shift_done = shift_busy && shift_advance && last_window;

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            shift_busy <= 1'b0;
            shift_idx <= '0;
        end
        else if (shift_kick)
        begin
            shift_busy <= 1'b1;
            shift_idx <= '0;
        end
        else if (shift_busy && shift_advance)
        begin
            if (last_window)
                shift_busy <= 1'b0;
            shift_idx <= shift_idx + 1'b1;
        end
    end

    // sliding window with zeros past the end of the line
    always_comb
    begin
        taps = '0;
        pos = '0;
        for (int t = 0; t < kNoOfTaps; t++)
        begin
            pos = {1'b0, shift_idx} + (kIndexLength + 1)'(t);
            if (pos < kLineLength)
                taps[t*kFilteredDataLength +: kFilteredDataLength] =
                    line_mem[pos[kIndexLength-1:0]];
        end
    end

    assign angle = line_angle;
    assign index = shift_idx;

endmodule

`default_nettype wire
